// File: hdl/dram_pkg.sv
`default_nettype none

package dram_pkg;

    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int STRB_W   = DATA_W / 8;
    localparam int ID_W     = 4;
    localparam int LEN_W    = 8;
    localparam int DRAM_A_W = 11;

    // Word address bits 12..2 are the column, bits 23..13 the row
    localparam int COL_LSB = 2;
    localparam int ROW_LSB = 13;

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [ID_W-1:0]     id_t;
    typedef logic [LEN_W-1:0]    len_t;
    typedef logic [1:0]          resp_t;
    typedef logic [DRAM_A_W-1:0] dram_addr_t;
    typedef logic [STRB_W-1:0]   dram_wen_t;

    localparam resp_t RESP_OKAY = 2'b00;

    typedef enum logic [2:0] {
        IDLE,
        OPEN_ROW,
        READ_COL,
        WRITE_COL,
        PRECHARGE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/axi_slave_if.sv
`default_nettype none

interface axi_slave_if import dram_pkg::*; ();

    logic  awvalid;
    logic  awready;
    addr_t awaddr;
    id_t   awid;
    len_t  awlen;

    logic  wvalid;
    logic  wready;
    data_t wdata;
    strb_t wstrb;
    logic  wlast;

    logic  bvalid;
    logic  bready;
    id_t   bid;
    resp_t bresp;

    logic  arvalid;
    logic  arready;
    addr_t araddr;
    id_t   arid;
    len_t  arlen;

    logic  rvalid;
    logic  rready;
    data_t rdata;
    id_t   rid;
    resp_t rresp;
    logic  rlast;

    modport master (
        output awvalid, awaddr, awid, awlen, wvalid, wdata, wstrb, wlast,
        output bready, arvalid, araddr, arid, arlen, rready,
        input  awready, wready, bvalid, bid, bresp, arready,
        input  rvalid, rdata, rid, rresp, rlast
    );

    // W channel is sunk by the write FIFO, not by the controller
    modport slave (
        input  awvalid, awaddr, awid, awlen, bready,
        input  arvalid, araddr, arid, arlen, rready,
        output awready, bvalid, bid, bresp, arready,
        output rvalid, rdata, rid, rresp, rlast
    );

endinterface

`default_nettype wire

// File: hdl/wdata_fifo.sv
`default_nettype none

module wdata_fifo import dram_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        push_i,
    input  wire data_t data_i,
    input  wire strb_t strb_i,
    input  wire        pop_i,
    output data_t      data_o,
    output strb_t      strb_o,
    output logic       empty_o,
    output logic       full_o
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    data_t            data_mem [FIFO_DEPTH];
    strb_t            strb_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == CNT_W'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    // Head entry goes straight out
    assign data_o = data_mem[rd_ptr_q];
    assign strb_o = strb_mem[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr_q] <= data_i;
            strb_mem[wr_ptr_q] <= strb_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/dram_ctrl.sv
`default_nettype none

module dram_ctrl import dram_pkg::*; #(
    parameter int T_RCD = 4,
    parameter int T_CAS = 4,
    parameter int T_RP  = 4
) (
    input  wire          clk,
    input  wire          rst,
    axi_slave_if.slave   slv,
    input  wire data_t   wq_data_i,
    input  wire strb_t   wq_strb_i,
    input  wire          wq_empty_i,
    output logic         wq_pop_o,
    input  wire data_t   dram_q_i,
    input  wire          dram_valid_i,
    output logic         dram_csn_o,
    output logic         dram_rasn_o,
    output logic         dram_casn_o,
    output dram_wen_t    dram_wen_o,
    output dram_addr_t   dram_a_o,
    output data_t        dram_d_o
);

    localparam int DLY_MAX = (T_RCD > T_CAS) ? ((T_RCD > T_RP) ? T_RCD : T_RP)
                                             : ((T_CAS > T_RP) ? T_CAS : T_RP);
    localparam int DLY_W   = $clog2(DLY_MAX + 1);

    ctrl_state_e      state_q;
    logic [DLY_W-1:0] dly_q;
    len_t             beat_q;
    logic             col_busy_q;
    logic             rvalid_q;
    logic             bvalid_q;
    logic             is_write_q;
    id_t              id_q;
    len_t             len_q;
    dram_addr_t       row_q;
    dram_addr_t       col_q;
    data_t            rdata_q;

    logic aw_hs;
    logic ar_hs;
    logic r_hs;
    logic b_hs;
    logic last_beat;
    logic rcd_done;
    logic cas_done;
    logic rp_done;
    logic rd_cas;
    logic wr_cas;

    assign slv.awready = (state_q == IDLE);
    // Write wins when both address channels are valid
    assign slv.arready = (state_q == IDLE) && !slv.awvalid;

    assign aw_hs     = slv.awvalid && slv.awready;
    assign ar_hs     = slv.arvalid && slv.arready;
    assign r_hs      = rvalid_q && slv.rready;
    assign b_hs      = bvalid_q && slv.bready;
    assign last_beat = (beat_q == len_q);

    assign rcd_done = (dly_q == DLY_W'(T_RCD - 1));
    assign cas_done = (dly_q == DLY_W'(T_CAS - 1));
    assign rp_done  = (dly_q == DLY_W'(T_RP - 1));

    // No new read CAS while a beat waits for data or for rready
    assign rd_cas   = (state_q == READ_COL) && !col_busy_q && !rvalid_q;
    assign wr_cas   = (state_q == WRITE_COL) && !col_busy_q && !wq_empty_i;
    assign wq_pop_o = (state_q == WRITE_COL) && col_busy_q && cas_done;

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q  <= slv.awid;
            len_q <= slv.awlen;
            row_q <= slv.awaddr[ROW_LSB +: DRAM_A_W];
            col_q <= slv.awaddr[COL_LSB +: DRAM_A_W];
        end else if (ar_hs) begin
            id_q  <= slv.arid;
            len_q <= slv.arlen;
            row_q <= slv.araddr[ROW_LSB +: DRAM_A_W];
            col_q <= slv.araddr[COL_LSB +: DRAM_A_W];
        end else if (r_hs || wq_pop_o) begin
            col_q <= col_q + 1'b1;
        end
        if (state_q == READ_COL && col_busy_q && dram_valid_i) begin
            rdata_q <= dram_q_i;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q    <= IDLE;
            dly_q      <= '0;
            beat_q     <= '0;
            col_busy_q <= 1'b0;
            rvalid_q   <= 1'b0;
            bvalid_q   <= 1'b0;
            is_write_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    dly_q  <= '0;
                    beat_q <= '0;
                    if (aw_hs || ar_hs) begin
                        is_write_q <= aw_hs;
                        state_q    <= OPEN_ROW;
                    end
                end
                OPEN_ROW: begin
                    if (rcd_done) begin
                        dly_q   <= '0;
                        state_q <= is_write_q ? WRITE_COL : READ_COL;
                    end else begin
                        dly_q <= dly_q + 1'b1;
                    end
                end
                READ_COL: begin
                    if (rd_cas) begin
                        col_busy_q <= 1'b1;
                    end else if (col_busy_q && dram_valid_i) begin
                        col_busy_q <= 1'b0;
                        rvalid_q   <= 1'b1;
                    end else if (r_hs) begin
                        rvalid_q <= 1'b0;
                        beat_q   <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= PRECHARGE;
                        end
                    end
                end
                WRITE_COL: begin
                    if (wr_cas) begin
                        col_busy_q <= 1'b1;
                        dly_q      <= '0;
                    end else if (col_busy_q) begin
                        if (cas_done) begin
                            col_busy_q <= 1'b0;
                            dly_q      <= '0;
                            beat_q     <= beat_q + 1'b1;
                            if (last_beat) begin
                                state_q <= PRECHARGE;
                            end
                        end else begin
                            dly_q <= dly_q + 1'b1;
                        end
                    end
                end
                PRECHARGE: begin
                    if (bvalid_q) begin
                        if (b_hs) begin
                            bvalid_q <= 1'b0;
                            state_q  <= IDLE;
                        end
                    end else if (rp_done) begin
                        if (is_write_q) begin
                            bvalid_q <= 1'b1;
                        end else begin
                            state_q <= IDLE;
                        end
                    end else begin
                        dly_q <= dly_q + 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_comb begin
        dram_csn_o  = 1'b0;
        dram_rasn_o = 1'b1;
        dram_casn_o = 1'b1;
        dram_wen_o  = '1;
        dram_a_o    = row_q;
        case (state_q)
            IDLE: begin
                dram_csn_o = 1'b1;
                dram_a_o   = '0;
            end
            OPEN_ROW: begin
                dram_rasn_o = (dly_q != '0);
            end
            READ_COL: begin
                dram_a_o    = col_q;
                dram_casn_o = !rd_cas;
            end
            WRITE_COL: begin
                dram_a_o    = col_q;
                dram_casn_o = !wr_cas;
                if (wr_cas) begin
                    dram_wen_o = ~wq_strb_i;
                end
            end
            PRECHARGE: begin
                // RAS and all byte enables low opens the precharge
                if (dly_q == '0 && !bvalid_q) begin
                    dram_rasn_o = 1'b0;
                    dram_wen_o  = '0;
                end
            end
            default: begin
                dram_csn_o = 1'b1;
            end
        endcase
    end

    assign dram_d_o = wq_data_i;

    assign slv.rvalid = rvalid_q;
    assign slv.rdata  = rdata_q;
    assign slv.rid    = id_q;
    assign slv.rresp  = RESP_OKAY;
    assign slv.rlast  = last_beat;
    assign slv.bvalid = bvalid_q;
    assign slv.bid    = id_q;
    assign slv.bresp  = RESP_OKAY;

endmodule

`default_nettype wire

// File: hdl/dram_subsys_top.sv
`default_nettype none

module dram_subsys_top import dram_pkg::*; #(
    parameter int T_RCD      = 4,
    parameter int T_CAS      = 4,
    parameter int T_RP       = 4,
    parameter int FIFO_DEPTH = 8
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        awvalid_i,
    input  wire addr_t awaddr_i,
    input  wire id_t   awid_i,
    input  wire len_t  awlen_i,
    input  wire        wvalid_i,
    input  wire data_t wdata_i,
    input  wire strb_t wstrb_i,
    input  wire        wlast_i,
    input  wire        bready_i,
    input  wire        arvalid_i,
    input  wire addr_t araddr_i,
    input  wire id_t   arid_i,
    input  wire len_t  arlen_i,
    input  wire        rready_i,
    output logic       awready_o,
    output logic       wready_o,
    output logic       bvalid_o,
    output id_t        bid_o,
    output resp_t      bresp_o,
    output logic       arready_o,
    output logic       rvalid_o,
    output data_t      rdata_o,
    output id_t        rid_o,
    output resp_t      rresp_o,
    output logic       rlast_o,
    input  wire data_t dram_q_i,
    input  wire        dram_valid_i,
    output logic       dram_csn_o,
    output logic       dram_rasn_o,
    output logic       dram_casn_o,
    output dram_wen_t  dram_wen_o,
    output dram_addr_t dram_a_o,
    output data_t      dram_d_o
);

    data_t wq_data;
    strb_t wq_strb;
    logic  wq_empty;
    logic  wq_full;
    logic  wq_pop;

    axi_slave_if axi ();

    assign axi.awvalid = awvalid_i;
    assign axi.awaddr  = awaddr_i;
    assign axi.awid    = awid_i;
    assign axi.awlen   = awlen_i;
    assign axi.wvalid  = wvalid_i;
    assign axi.wdata   = wdata_i;
    assign axi.wstrb   = wstrb_i;
    assign axi.wlast   = wlast_i;
    assign axi.bready  = bready_i;
    assign axi.arvalid = arvalid_i;
    assign axi.araddr  = araddr_i;
    assign axi.arid    = arid_i;
    assign axi.arlen   = arlen_i;
    assign axi.rready  = rready_i;

    // Write beats are accepted whenever the buffer has room
    assign axi.wready = !wq_full;

    assign awready_o = axi.awready;
    assign wready_o  = axi.wready;
    assign bvalid_o  = axi.bvalid;
    assign bid_o     = axi.bid;
    assign bresp_o   = axi.bresp;
    assign arready_o = axi.arready;
    assign rvalid_o  = axi.rvalid;
    assign rdata_o   = axi.rdata;
    assign rid_o     = axi.rid;
    assign rresp_o   = axi.rresp;
    assign rlast_o   = axi.rlast;

    wdata_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_wfifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (axi.wvalid && axi.wready),
        .data_i  (axi.wdata),
        .strb_i  (axi.wstrb),
        .pop_i   (wq_pop),
        .data_o  (wq_data),
        .strb_o  (wq_strb),
        .empty_o (wq_empty),
        .full_o  (wq_full)
    );

    dram_ctrl #(
        .T_RCD (T_RCD),
        .T_CAS (T_CAS),
        .T_RP  (T_RP)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .slv          (axi.slave),
        .wq_data_i    (wq_data),
        .wq_strb_i    (wq_strb),
        .wq_empty_i   (wq_empty),
        .wq_pop_o     (wq_pop),
        .dram_q_i     (dram_q_i),
        .dram_valid_i (dram_valid_i),
        .dram_csn_o   (dram_csn_o),
        .dram_rasn_o  (dram_rasn_o),
        .dram_casn_o  (dram_casn_o),
        .dram_wen_o   (dram_wen_o),
        .dram_a_o     (dram_a_o),
        .dram_d_o     (dram_d_o)
    );

endmodule

`default_nettype wire

// File: dv/dram_model.sv
`default_nettype none

module dram_model import dram_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             csn_i,
    input  wire             rasn_i,
    input  wire             casn_i,
    input  wire dram_wen_t  wen_i,
    input  wire dram_addr_t a_i,
    input  wire data_t      d_i,
    output data_t           q_o,
    output logic            valid_o
);

    data_t      mem [4096];
    dram_addr_t row_q;
    logic [1:0] vld_pipe;
    data_t      q_pipe [2];
    logic [11:0] idx;

    // Low row bit and the column select one word
    assign idx     = {row_q[0], a_i};
    assign q_o     = q_pipe[1];
    assign valid_o = vld_pipe[1];

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            vld_pipe <= 2'b00;
            row_q    <= '0;
        end else begin
            vld_pipe  <= {vld_pipe[0], 1'b0};
            q_pipe[1] <= q_pipe[0];
            // RAS with all byte enables low is a precharge
            if (!csn_i && !rasn_i && wen_i == '1) begin
                row_q <= a_i;
            end
            if (!csn_i && !casn_i) begin
                if (wen_i == '1) begin
                    vld_pipe[0] <= 1'b1;
                    q_pipe[0]   <= mem[idx];
                end else begin
                    for (int b = 0; b < STRB_W; b++) begin
                        if (!wen_i[b]) begin
                            mem[idx][8*b +: 8] <= d_i[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_checker.sv
`default_nettype none

module tb_checker import dram_pkg::*; #(
    parameter int NAME_W = 96
) (
    input  wire              clk,
    input  wire              rst,
    input  wire [NAME_W-1:0] test_name_i,
    input  wire              awvalid_i,
    input  wire              awready_i,
    input  wire addr_t       awaddr_i,
    input  wire id_t         awid_i,
    input  wire len_t        awlen_i,
    input  wire              wvalid_i,
    input  wire              wready_i,
    input  wire data_t       wdata_i,
    input  wire strb_t       wstrb_i,
    input  wire              bvalid_i,
    input  wire              bready_i,
    input  wire id_t         bid_i,
    input  wire resp_t       bresp_i,
    input  wire              arvalid_i,
    input  wire              arready_i,
    input  wire addr_t       araddr_i,
    input  wire id_t         arid_i,
    input  wire len_t        arlen_i,
    input  wire              rvalid_i,
    input  wire              rready_i,
    input  wire data_t       rdata_i,
    input  wire id_t         rid_i,
    input  wire resp_t       rresp_i,
    input  wire              rlast_i,
    input  wire              dram_csn_i,
    input  wire              dram_rasn_i,
    input  wire              dram_casn_i,
    input  wire dram_wen_t   dram_wen_i,
    input  wire dram_addr_t  dram_a_i,
    input  wire data_t       dram_d_i,
    output int               err_count_o
);

    data_t       ref_mem [4096];
    data_t       w_data_q [$];
    strb_t       w_strb_q [$];
    data_t       wd_exp;
    dram_wen_t   wen_exp;
    logic        wr_txn_q;
    logic [11:0] wr_word_q;
    logic [11:0] rd_word_q;
    logic [11:0] idx;
    id_t         aw_id_q;
    id_t         ar_id_q;
    len_t        ar_len_q;
    len_t        w_beat_q;
    len_t        r_beat_q;
    len_t        cas_cnt_q;
    dram_addr_t  row_exp_q;
    dram_addr_t  col_exp_q;
    dram_addr_t  col_exp;
    int          errors = 0;
    // Cycles since reset release, parked past the window until a reset is seen
    int          post_rst_q = 2;

    assign err_count_o = errors;

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("error %0s %0s: expected %h, actual %h", test_name_i, what, exp, act);
        errors++;
    endtask

    function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t strb);
        data_t res;
        res = old;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = wd[8*b +: 8];
            end
        end
        return res;
    endfunction

    always @(posedge clk) begin
        if (!rst || post_rst_q < 2) begin
            if ({dram_csn_i, dram_rasn_i, dram_casn_i} !== 3'b111) begin
                mismatch("csn/rasn/casn", 3'b111, {dram_csn_i, dram_rasn_i, dram_casn_i});
            end
            if (dram_wen_i !== '1) begin
                mismatch("wen", 4'hf, dram_wen_i);
            end
            if ({rvalid_i, bvalid_i} !== 2'b00) begin
                mismatch("rvalid/bvalid", 2'b00, {rvalid_i, bvalid_i});
            end
        end
        post_rst_q = rst ? post_rst_q + 1 : 0;

        if (rst) begin
            if (awvalid_i && awready_i) begin
                wr_word_q = awaddr_i[13:2];
                aw_id_q   = awid_i;
                w_beat_q  = '0;
                cas_cnt_q = '0;
                wr_txn_q  = 1'b1;
                row_exp_q = awaddr_i[23:13];
                col_exp_q = awaddr_i[12:2];
            end
            if (arvalid_i && arready_i) begin
                rd_word_q = araddr_i[13:2];
                ar_id_q   = arid_i;
                ar_len_q  = arlen_i;
                r_beat_q  = '0;
                cas_cnt_q = '0;
                wr_txn_q  = 1'b0;
                row_exp_q = araddr_i[23:13];
                col_exp_q = araddr_i[12:2];
            end
            if (wvalid_i && wready_i) begin
                idx          = wr_word_q + 12'(w_beat_q);
                ref_mem[idx] = merge_bytes(ref_mem[idx], wdata_i, wstrb_i);
                w_data_q.push_back(wdata_i);
                w_strb_q.push_back(wstrb_i);
                w_beat_q++;
            end
            if (!dram_csn_i && !dram_rasn_i && dram_wen_i == '1) begin
                if (dram_a_i !== row_exp_q) begin
                    mismatch("row address", row_exp_q, dram_a_i);
                end
            end
            if (!dram_casn_i) begin
                if (rvalid_i) begin
                    $display("error %0s: CAS issued while a read beat waits for rready",
                             test_name_i);
                    errors++;
                end
                col_exp = col_exp_q + 11'(cas_cnt_q);
                if (dram_a_i !== col_exp) begin
                    mismatch("column address", col_exp, dram_a_i);
                end
                if (wr_txn_q) begin
                    if (w_data_q.size() == 0) begin
                        $display("error %0s: write CAS issued before any write beat arrived",
                                 test_name_i);
                        errors++;
                    end else begin
                        wd_exp  = w_data_q.pop_front();
                        wen_exp = ~w_strb_q.pop_front();
                        if (dram_d_i !== wd_exp) begin
                            mismatch("dram data", wd_exp, dram_d_i);
                        end
                        if (dram_wen_i !== wen_exp) begin
                            mismatch("write enables", wen_exp, dram_wen_i);
                        end
                    end
                end
                cas_cnt_q++;
            end
            if (rvalid_i && rready_i) begin
                idx = rd_word_q + 12'(r_beat_q);
                if (rdata_i !== ref_mem[idx]) begin
                    mismatch("rdata", ref_mem[idx], rdata_i);
                end
                if (rid_i !== ar_id_q) begin
                    mismatch("rid", ar_id_q, rid_i);
                end
                if (rresp_i !== RESP_OKAY) begin
                    mismatch("rresp", RESP_OKAY, rresp_i);
                end
                if (rlast_i !== (r_beat_q == ar_len_q)) begin
                    mismatch("rlast", r_beat_q == ar_len_q, rlast_i);
                end
                r_beat_q++;
            end
            if (bvalid_i && bready_i) begin
                if (bid_i !== aw_id_q) begin
                    mismatch("bid", aw_id_q, bid_i);
                end
                if (bresp_i !== RESP_OKAY) begin
                    mismatch("bresp", RESP_OKAY, bresp_i);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_dram_subsys.sv
`default_nettype none

module tb_dram_subsys import dram_pkg::*; ();

    localparam int T_RCD      = 4;
    localparam int T_CAS      = 4;
    localparam int T_RP       = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int NAME_W     = 96;
    localparam int NUM_TESTS  = 9;

    logic clk;
    logic rst;
    logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
    logic arvalid, arready, rvalid, rready, rlast;
    addr_t awaddr, araddr;
    id_t   awid, arid, bid, rid;
    len_t  awlen, arlen;
    data_t wdata, rdata, dram_q, dram_d;
    strb_t wstrb;
    resp_t bresp, rresp;
    logic  dram_valid, dram_csn, dram_rasn, dram_casn;
    dram_wen_t  dram_wen;
    dram_addr_t dram_a;

    logic [NAME_W-1:0] tab_name [NUM_TESTS];
    logic              tab_write [NUM_TESTS];
    addr_t             tab_addr [NUM_TESTS];
    len_t              tab_len [NUM_TESTS];
    id_t               tab_id [NUM_TESTS];
    data_t             tab_base [NUM_TESTS];
    strb_t             tab_strb [NUM_TESTS];
    logic              tab_stall [NUM_TESTS];
    int                n_tests = 0;

    logic [NAME_W-1:0] test_name;
    logic [31:0]       lcg_state;
    int                err_count;
    int unsigned       timeout_limit = 0;
    int unsigned       cycle_cnt = 0;

    dram_subsys_top #(
        .T_RCD      (T_RCD),
        .T_CAS      (T_CAS),
        .T_RP       (T_RP),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_dut (
        .clk          (clk),
        .rst          (rst),
        .awvalid_i    (awvalid),
        .awaddr_i     (awaddr),
        .awid_i       (awid),
        .awlen_i      (awlen),
        .wvalid_i     (wvalid),
        .wdata_i      (wdata),
        .wstrb_i      (wstrb),
        .wlast_i      (wlast),
        .bready_i     (bready),
        .arvalid_i    (arvalid),
        .araddr_i     (araddr),
        .arid_i       (arid),
        .arlen_i      (arlen),
        .rready_i     (rready),
        .awready_o    (awready),
        .wready_o     (wready),
        .bvalid_o     (bvalid),
        .bid_o        (bid),
        .bresp_o      (bresp),
        .arready_o    (arready),
        .rvalid_o     (rvalid),
        .rdata_o      (rdata),
        .rid_o        (rid),
        .rresp_o      (rresp),
        .rlast_o      (rlast),
        .dram_q_i     (dram_q),
        .dram_valid_i (dram_valid),
        .dram_csn_o   (dram_csn),
        .dram_rasn_o  (dram_rasn),
        .dram_casn_o  (dram_casn),
        .dram_wen_o   (dram_wen),
        .dram_a_o     (dram_a),
        .dram_d_o     (dram_d)
    );

    dram_model u_mem (
        .clk     (clk),
        .rst     (rst),
        .csn_i   (dram_csn),
        .rasn_i  (dram_rasn),
        .casn_i  (dram_casn),
        .wen_i   (dram_wen),
        .a_i     (dram_a),
        .d_i     (dram_d),
        .q_o     (dram_q),
        .valid_o (dram_valid)
    );

    tb_checker #(
        .NAME_W (NAME_W)
    ) u_chk (
        .clk         (clk),
        .rst         (rst),
        .test_name_i (test_name),
        .awvalid_i   (awvalid),
        .awready_i   (awready),
        .awaddr_i    (awaddr),
        .awid_i      (awid),
        .awlen_i     (awlen),
        .wvalid_i    (wvalid),
        .wready_i    (wready),
        .wdata_i     (wdata),
        .wstrb_i     (wstrb),
        .bvalid_i    (bvalid),
        .bready_i    (bready),
        .bid_i       (bid),
        .bresp_i     (bresp),
        .arvalid_i   (arvalid),
        .arready_i   (arready),
        .araddr_i    (araddr),
        .arid_i      (arid),
        .arlen_i     (arlen),
        .rvalid_i    (rvalid),
        .rready_i    (rready),
        .rdata_i     (rdata),
        .rid_i       (rid),
        .rresp_i     (rresp),
        .rlast_i     (rlast),
        .dram_csn_i  (dram_csn),
        .dram_rasn_i (dram_rasn),
        .dram_casn_i (dram_casn),
        .dram_wen_i  (dram_wen),
        .dram_a_i    (dram_a),
        .dram_d_i    (dram_d),
        .err_count_o (err_count)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_test(input logic [NAME_W-1:0] name, input logic wr, input addr_t addr,
                            input len_t len, input id_t id, input data_t base,
                            input strb_t strb, input logic stall);
        tab_name[n_tests]  = name;
        tab_write[n_tests] = wr;
        tab_addr[n_tests]  = addr;
        tab_len[n_tests]   = len;
        tab_id[n_tests]    = id;
        tab_base[n_tests]  = base;
        tab_strb[n_tests]  = strb;
        tab_stall[n_tests] = stall;
        n_tests++;
    endtask

    task automatic wait_valid(input logic is_b);
        @(posedge clk);
        while (!(is_b ? bvalid : rvalid)) begin
            @(posedge clk);
        end
    endtask

    // One R beat or the B response, with optional ready stall
    task automatic take_response(input logic is_b, input logic stall);
        int n;
        n = 0;
        if (stall) begin
            lcg_state = lcg_next(lcg_state);
            n = lcg_state[17:16];
            wait_valid(is_b);
            repeat (n) @(posedge clk);
            @(negedge clk);
        end
        if (is_b) bready = 1'b1;
        else rready = 1'b1;
        wait_valid(is_b);
        @(negedge clk);
        bready = 1'b0;
        rready = 1'b0;
    endtask

    task automatic run_write(input int t);
        int b;
        awvalid = 1'b1;
        awaddr  = tab_addr[t];
        awid    = tab_id[t];
        awlen   = tab_len[t];
        @(posedge clk);
        while (!awready) @(posedge clk);
        @(negedge clk);
        awvalid = 1'b0;
        for (b = 0; b <= int'(tab_len[t]); b++) begin
            wvalid = 1'b1;
            wdata  = tab_base[t] + data_t'(b);
            wstrb  = tab_strb[t];
            wlast  = (b == int'(tab_len[t]));
            @(posedge clk);
            while (!wready) @(posedge clk);
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast  = 1'b0;
        take_response(1'b1, tab_stall[t]);
    endtask

    task automatic run_read(input int t);
        int b;
        arvalid = 1'b1;
        araddr  = tab_addr[t];
        arid    = tab_id[t];
        arlen   = tab_len[t];
        @(posedge clk);
        while (!arready) @(posedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        for (b = 0; b <= int'(tab_len[t]); b++) begin
            take_response(1'b0, tab_stall[t]);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_limit != 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: transactions did not finish within %0d cycles", timeout_limit);
            $display("checker errors: %0d, timeouts: 1", err_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        {awvalid, wvalid, wlast, bready, arvalid, rready} = '0;
        awaddr    = '0;
        awid      = '0;
        awlen     = '0;
        wdata     = '0;
        wstrb     = '0;
        araddr    = '0;
        arid      = '0;
        arlen     = '0;
        test_name = "reset";
        lcg_state = 32'hf0c4_54ba;

        // name, write, address, length-1, id, base data, strobes, stall
        add_test("wr_single",   1'b1, 32'h0000_2010, 8'd0, 4'd3,  32'h1234_5678, 4'hf, 1'b0);
        add_test("rd_single",   1'b0, 32'h0000_2010, 8'd0, 4'd5,  32'h0,         4'hf, 1'b0);
        add_test("wr_burst4",   1'b1, 32'h0000_0100, 8'd3, 4'd7,  32'ha000_0000, 4'hf, 1'b0);
        add_test("rd_burst4",   1'b0, 32'h0000_0100, 8'd3, 4'd9,  32'h0,         4'hf, 1'b0);
        add_test("wr_partial",  1'b1, 32'h0000_0100, 8'd0, 4'd2,  32'h5566_7788, 4'h5, 1'b0);
        add_test("rd_partial",  1'b0, 32'h0000_0100, 8'd0, 4'd4,  32'h0,         4'hf, 1'b0);
        add_test("rd_stall4",   1'b0, 32'h0000_0100, 8'd3, 4'd11, 32'h0,         4'hf, 1'b1);
        add_test("wr_stall",    1'b1, 32'h0000_3ff0, 8'd3, 4'd12, 32'hc0de_0000, 4'hf, 1'b1);
        add_test("rd_stall_hi", 1'b0, 32'h0000_3ff0, 8'd3, 4'd13, 32'h0,         4'hf, 1'b1);

        // Reset cycles plus per-beat and per-transaction budget
        timeout_limit = 16;
        for (int i = 0; i < n_tests; i++) begin
            timeout_limit += (int'(tab_len[i]) + 1) * (T_CAS + 8) + 40;
        end

        @(negedge clk);
        rst = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);

        for (int i = 0; i < n_tests; i++) begin
            test_name = tab_name[i];
            if (tab_write[i]) begin
                run_write(i);
            end else begin
                run_read(i);
            end
            repeat (2) @(negedge clk);
        end

        repeat (4) @(negedge clk);
        $display("checker errors: %0d, timeouts: 0", err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
hdl/dram_pkg.sv
hdl/axi_slave_if.sv
hdl/wdata_fifo.sv
hdl/dram_ctrl.sv
hdl/dram_subsys_top.sv
dv/dram_model.sv
dv/tb_checker.sv
dv/tb_dram_subsys.sv

// File: Bender.yml
package:
  name: dram_subsys

sources:
  - hdl/dram_pkg.sv
  - hdl/axi_slave_if.sv
  - hdl/wdata_fifo.sv
  - hdl/dram_ctrl.sv
  - hdl/dram_subsys_top.sv
  - target: test
    files:
      - dv/dram_model.sv
      - dv/tb_checker.sv
      - dv/tb_dram_subsys.sv
